// File: cmd_engine.f
common/queue_pkg.sv
common/cmd_pkg.sv
fifo/fifo_memory.sv
fifo/fifo_controller.sv
src/cmd_intake.sv
src/cmd_decode.sv
src/cmd_execute.sv
src/result_stage.sv
src/cmd_engine_top.sv
verification/cmd_engine_asserts.sv
verification/tb_cmd_engine.sv

// File: verification/tb_cmd_engine.sv
// Command engine testbench
module tb_cmd_engine
  import queue_pkg::*;
  import cmd_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DIRECTED_CMDS  = 14;
  localparam int RANDOM_CMDS    = 200;
  localparam int STALL_CMDS     = 48;
  // Commands the DUT can hold before in_ack must wait
  localparam int IN_FLIGHT      = CMD_DEPTH + RES_DEPTH + 3;
  localparam int TIMEOUT_CYCLES = (DIRECTED_CMDS + RANDOM_CMDS + STALL_CMDS) * 40 + 200;

  logic                clock;
  logic                resetn;
  logic                in_req;
  logic [2:0]          in_opcode;
  logic [DATA_W-1:0]   in_a;
  logic [DATA_W-1:0]   in_b;
  logic [TAG_W-1:0]    in_tag;
  logic                in_ack;
  logic                out_req;
  logic                out_ack;
  logic [TAG_W-1:0]    out_tag;
  logic [DATA_W-1:0]   out_value;
  logic                out_flag;

  integer    seed;
  int        cycle_count;
  int        errors;
  int        test_checks;
  int        test_errors;
  int        tests_run;
  int        tests_failed;
  int        max_ack_wait;
  // Commands still to send, results still to arrive
  cmd_t      stimulus[$];
  result_t   expected_q[$];

  cmd_engine_top dut_i (
    .clock     (clock),
    .resetn    (resetn),
    .in_req    (in_req),
    .in_opcode (in_opcode),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_tag    (in_tag),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_tag   (out_tag),
    .out_value (out_value),
    .out_flag  (out_flag)
  );

  bind cmd_engine_top cmd_engine_asserts asserts_i (
    .clock     (clock),
    .resetn    (resetn),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_tag   (out_tag),
    .out_value (out_value),
    .out_flag  (out_flag)
  );

  // 40 ns period
  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic int rand_below(input int limit);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % limit;
  endfunction

  function automatic cmd_t make_cmd(input opcode_e op, input logic [15:0] a,
                                    input logic [15:0] b, input logic [3:0] tag);
    cmd_t c;
    c.opcode = op;
    c.a      = a;
    c.b      = b;
    c.tag    = tag;
    return c;
  endfunction

  function automatic cmd_t random_command();
    cmd_t c;
    c.opcode = opcode_e'(rand_below(8));
    c.a      = $random(seed);
    c.b      = $random(seed);
    c.tag    = $random(seed);
    return c;
  endfunction

  // Reference model from the opcode rules
  function automatic result_t model_result(input cmd_t c);
    result_t     r;
    logic [31:0] wide;
    r.tag  = c.tag;
    r.flag = 1'b0;
    wide   = 32'(c.a) + 32'(c.b);
    case (c.opcode)
      ADD: begin
        r.value = wide[15:0];
        r.flag  = (wide > 32'h0000_ffff);
      end
      SUB: begin
        r.value = c.a - c.b;
        r.flag  = (c.a < c.b);
      end
      AND: r.value = c.a & c.b;
      OR:  r.value = c.a | c.b;
      XOR: r.value = c.a ^ c.b;
      // Shift amount is b modulo 16
      SHL: r.value = c.a << c.b[3:0];
      SHR: r.value = c.a >> c.b[3:0];
      MAX: r.value = (c.a >= c.b) ? c.a : c.b;
      default: r.value = '0;
    endcase
    return r;
  endfunction

  task automatic check_result(input string what, input result_t got, input result_t expected);
    test_checks++;
    if (got !== expected) begin
      $display("mismatch out_tag/out_value/out_flag (%s): got %h/%h/%h expected %h/%h/%h",
               what, got.tag, got.value, got.flag, expected.tag, expected.value, expected.flag);
      test_errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic expected);
    test_checks++;
    if (got !== expected) begin
      $display("mismatch %s: got %h expected %h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-13s %s  checks %0d  errors %0d", name,
             (test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    errors      += test_errors;
    test_checks  = 0;
    test_errors  = 0;
  endtask

  // Producer side, one four-phase handshake
  task automatic send_command(input cmd_t c);
    int wait_cycles;
    wait_cycles = 0;
    in_opcode   = c.opcode;
    in_a        = c.a;
    in_b        = c.b;
    in_tag      = c.tag;
    in_req      = 1'b1;
    expected_q.push_back(model_result(c));
    do begin
      @(negedge clock);
      wait_cycles++;
    end while (!in_ack);
    if (wait_cycles > max_ack_wait) begin
      max_ack_wait = wait_cycles;
    end
    // Req held one more cycle, ack must not drop yet
    @(negedge clock);
    check_level("in_ack", in_ack, 1'b1);
    in_req = 1'b0;
    do begin
      @(negedge clock);
    end while (in_ack);
  endtask

  // Consumer side, mode sets how long ack is held back
  task automatic collect_results(input int count, input int mode);
    result_t got;
    result_t held;
    int      delay;
    int      linger;
    int      i;
    for (i = 0; i < count; i++) begin
      do begin
        @(negedge clock);
      end while (!out_req);
      got.tag   = out_tag;
      got.value = out_value;
      got.flag  = out_flag;
      case (mode)
        0: delay = 0;
        1: delay = rand_below(4);
        default: delay = (i % 12 == 0) ? 8 * IN_FLIGHT + rand_below(20) : rand_below(3);
      endcase
      repeat (delay) @(negedge clock);
      held.tag   = out_tag;
      held.value = out_value;
      held.flag  = out_flag;
      check_result("held until ack", held, got);
      check_level("out_req", out_req, 1'b1);
      out_ack = 1'b1;
      do begin
        @(negedge clock);
      end while (out_req);
      // Keep ack up after req falls to hold off the next entry
      linger = (mode == 0) ? 0 : rand_below(4);
      repeat (linger) begin
        @(negedge clock);
        check_level("out_req", out_req, 1'b0);
      end
      out_ack = 1'b0;
      if (expected_q.size() == 0) begin
        $display("a result arrived with no command outstanding");
        test_errors++;
      end else begin
        check_result("in order", got, expected_q.pop_front());
      end
    end
  endtask

  // Both ports quiet for a while
  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      check_level("in_ack", in_ack, 1'b0);
      check_level("out_req", out_req, 1'b0);
    end
  endtask

  task automatic run_stream(input int mode);
    int count;
    count = stimulus.size();
    fork
      begin
        foreach (stimulus[k]) begin
          send_command(stimulus[k]);
        end
      end
      collect_results(count, mode);
    join
    stimulus.delete();
    // Catches duplicated results
    expect_idle(20);
  endtask

  initial begin
    seed         = 32'h36e2_9835;
    resetn       = 1'b0;
    in_req       = 1'b0;
    in_opcode    = '0;
    in_a         = '0;
    in_b         = '0;
    in_tag       = '0;
    out_ack      = 1'b0;
    errors       = 0;
    test_checks  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    max_ack_wait = 0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;

    expect_idle(6);
    report_test("reset_idle");

    // Carry, borrow, shift 0 and 15, unsigned max
    stimulus.push_back(make_cmd(ADD, 16'hffff, 16'h0001, 4'h0));
    stimulus.push_back(make_cmd(ADD, 16'h1234, 16'h4321, 4'h1));
    stimulus.push_back(make_cmd(SUB, 16'h0001, 16'h0002, 4'h2));
    stimulus.push_back(make_cmd(SUB, 16'h8000, 16'h0001, 4'h3));
    stimulus.push_back(make_cmd(AND, 16'hf0f0, 16'hff00, 4'h4));
    stimulus.push_back(make_cmd(OR,  16'hf0f0, 16'h0f0f, 4'h5));
    stimulus.push_back(make_cmd(XOR, 16'haaaa, 16'hffff, 4'h6));
    stimulus.push_back(make_cmd(SHL, 16'h8001, 16'hfff0, 4'h7));
    stimulus.push_back(make_cmd(SHL, 16'h0001, 16'h000f, 4'h8));
    stimulus.push_back(make_cmd(SHR, 16'h8000, 16'h000f, 4'h9));
    stimulus.push_back(make_cmd(SHR, 16'h1234, 16'h1230, 4'ha));
    stimulus.push_back(make_cmd(MAX, 16'h7fff, 16'h8000, 4'hb));
    stimulus.push_back(make_cmd(MAX, 16'hffff, 16'h0001, 4'hc));
    stimulus.push_back(make_cmd(MAX, 16'h0005, 16'h0005, 4'hd));
    run_stream(0);
    report_test("opcodes");

    repeat (RANDOM_CMDS) stimulus.push_back(random_command());
    run_stream(1);
    report_test("random_order");

    max_ack_wait = 0;
    repeat (STALL_CMDS) stimulus.push_back(random_command());
    run_stream(2);
    if (max_ack_wait <= IN_FLIGHT) begin
      $display("in_ack was never held back while out_ack was withheld");
      test_errors++;
    end
    report_test("back_pressure");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: verification/cmd_engine_asserts.sv
// Four-phase port assertions
module cmd_engine_asserts
  import cmd_pkg::*;
(
  input logic                clock,
  input logic                resetn,
  input logic                in_req,
  input logic                in_ack,
  input logic                out_req,
  input logic                out_ack,
  input logic [TAG_W-1:0]    out_tag,
  input logic [DATA_W-1:0]   out_value,
  input logic                out_flag
);

  timeunit 1ns;
  timeprecision 1ps;

  // Ack may only drop once req has dropped
  in_ack_held: assert property (@(posedge clock) disable iff (!resetn)
    in_ack && in_req |=> in_ack)
    else $error("in_ack fell while in_req was still high");

  // No ack without a request
  in_ack_needs_req: assert property (@(posedge clock) disable iff (!resetn)
    !in_ack && !in_req |=> !in_ack)
    else $error("in_ack rose without in_req");

  // Req stays up until acknowledged
  out_req_held: assert property (@(posedge clock) disable iff (!resetn)
    out_req && !out_ack |=> out_req)
    else $error("out_req fell before out_ack");

  out_data_stable: assert property (@(posedge clock) disable iff (!resetn)
    out_req && !out_ack |=> $stable({out_tag, out_value, out_flag}))
    else $error("output data changed while out_req was high");

  // Next request waits for ack to return low
  out_req_waits: assert property (@(posedge clock) disable iff (!resetn)
    !out_req && out_ack |=> !out_req)
    else $error("out_req rose while out_ack was still high");

endmodule

// File: src/cmd_engine_top.sv
// Queued command engine top level
module cmd_engine_top
  import queue_pkg::*;
  import cmd_pkg::*;
(
  input  logic                clock,
  input  logic                resetn,
  // Command input port
  input  logic                in_req,
  input  logic [2:0]          in_opcode,
  input  logic [DATA_W-1:0]   in_a,
  input  logic [DATA_W-1:0]   in_b,
  input  logic [TAG_W-1:0]    in_tag,
  output logic                in_ack,
  // Result output port
  output logic                out_req,
  input  logic                out_ack,
  output logic [TAG_W-1:0]    out_tag,
  output logic [DATA_W-1:0]   out_value,
  output logic                out_flag
);

  // Command queue
  logic                           cmd_write;
  cmd_t                           cmd_wdata;
  logic                           cmd_full;
  logic                           cmd_read;
  cmd_t                           cmd_rdata;
  logic                           cmd_grant;
  logic                           cmd_mem_we;
  logic [$clog2(CMD_DEPTH)-1:0]   cmd_mem_address;
  cmd_t                           cmd_mem_wdata;
  cmd_t                           cmd_mem_rdata;

  // Decode to execute
  logic                           dec_valid;
  opcode_e                        dec_op;
  logic [DATA_W-1:0]              dec_a;
  logic [DATA_W-1:0]              dec_b;
  logic [TAG_W-1:0]               dec_tag;
  logic                           exe_ready;

  // Execute to result stage
  logic                           exe_valid;
  result_t                        exe_result;
  logic                           res_ready;

  // Result queue
  logic                           res_write;
  result_t                        res_wdata;
  logic                           res_full;
  logic                           res_read;
  result_t                        res_rdata;
  logic                           res_grant;
  logic                           res_mem_we;
  logic [$clog2(RES_DEPTH)-1:0]   res_mem_address;
  result_t                        res_mem_wdata;
  result_t                        res_mem_rdata;

  cmd_intake intake_i (
    .clock       (clock),
    .resetn      (resetn),
    .in_req      (in_req),
    .in_opcode   (in_opcode),
    .in_a        (in_a),
    .in_b        (in_b),
    .in_tag      (in_tag),
    .in_ack      (in_ack),
    .queue_full  (cmd_full),
    .queue_write (cmd_write),
    .queue_data  (cmd_wdata)
  );

  fifo_controller #(
    .PAYLOAD_T (cmd_t),
    .DEPTH     (CMD_DEPTH)
  ) cmd_fifo_i (
    .clock               (clock),
    .resetn              (resetn),
    .write_enable        (cmd_write),
    .write_data          (cmd_wdata),
    .full                (cmd_full),
    .read_enable         (cmd_read),
    .read_data           (cmd_rdata),
    .empty               (),
    .read_grant          (cmd_grant),
    .memory_write_enable (cmd_mem_we),
    .memory_address      (cmd_mem_address),
    .memory_write_data   (cmd_mem_wdata),
    .memory_read_data    (cmd_mem_rdata)
  );

  fifo_memory #(
    .PAYLOAD_T (cmd_t),
    .DEPTH     (CMD_DEPTH)
  ) cmd_mem_i (
    .clock        (clock),
    .write_enable (cmd_mem_we),
    .address      (cmd_mem_address),
    .write_data   (cmd_mem_wdata),
    .read_data    (cmd_mem_rdata)
  );

  cmd_decode decode_i (
    .clock       (clock),
    .resetn      (resetn),
    .queue_grant (cmd_grant),
    .queue_data  (cmd_rdata),
    .queue_read  (cmd_read),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_tag     (dec_tag),
    .exe_ready   (exe_ready)
  );

  cmd_execute execute_i (
    .clock      (clock),
    .resetn     (resetn),
    .dec_valid  (dec_valid),
    .dec_op     (dec_op),
    .dec_a      (dec_a),
    .dec_b      (dec_b),
    .dec_tag    (dec_tag),
    .exe_ready  (exe_ready),
    .exe_valid  (exe_valid),
    .exe_result (exe_result),
    .res_ready  (res_ready)
  );

  result_stage result_i (
    .clock       (clock),
    .resetn      (resetn),
    .exe_valid   (exe_valid),
    .exe_result  (exe_result),
    .res_ready   (res_ready),
    .queue_full  (res_full),
    .queue_write (res_write),
    .queue_wdata (res_wdata),
    .queue_grant (res_grant),
    .queue_rdata (res_rdata),
    .queue_read  (res_read),
    .out_req     (out_req),
    .out_ack     (out_ack),
    .out_tag     (out_tag),
    .out_value   (out_value),
    .out_flag    (out_flag)
  );

  fifo_controller #(
    .PAYLOAD_T (result_t),
    .DEPTH     (RES_DEPTH)
  ) res_fifo_i (
    .clock               (clock),
    .resetn              (resetn),
    .write_enable        (res_write),
    .write_data          (res_wdata),
    .full                (res_full),
    .read_enable         (res_read),
    .read_data           (res_rdata),
    .empty               (),
    .read_grant          (res_grant),
    .memory_write_enable (res_mem_we),
    .memory_address      (res_mem_address),
    .memory_write_data   (res_mem_wdata),
    .memory_read_data    (res_mem_rdata)
  );

  fifo_memory #(
    .PAYLOAD_T (result_t),
    .DEPTH     (RES_DEPTH)
  ) res_mem_i (
    .clock        (clock),
    .write_enable (res_mem_we),
    .address      (res_mem_address),
    .write_data   (res_mem_wdata),
    .read_data    (res_mem_rdata)
  );

endmodule

// File: src/result_stage.sv
// Result queue and four-phase sender
module result_stage
  import cmd_pkg::*;
(
  input  logic                clock,
  input  logic                resetn,
  // From execute
  input  logic                exe_valid,
  input  result_t             exe_result,
  output logic                res_ready,
  // Result queue write side
  input  logic                queue_full,
  output logic                queue_write,
  output result_t             queue_wdata,
  // Result queue read side
  input  logic                queue_grant,
  input  result_t             queue_rdata,
  output logic                queue_read,
  // Consumer port
  output logic                out_req,
  input  logic                out_ack,
  output logic [TAG_W-1:0]    out_tag,
  output logic [DATA_W-1:0]   out_value,
  output logic                out_flag
);

  typedef enum logic {
    SEND_IDLE,
    SEND_REQ
  } send_state_e;

  send_state_e send_state;

  // Write side, execute stalls while the queue is full
  assign res_ready   = !queue_full;
  assign queue_write = exe_valid && !queue_full;
  assign queue_wdata = exe_result;

  // Pop only once the previous ack has returned to zero
  assign queue_read = (send_state == SEND_IDLE) && !out_ack && queue_grant;
  assign out_req    = (send_state == SEND_REQ);

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      send_state <= SEND_IDLE;
    end else begin
      case (send_state)
        SEND_IDLE: begin
          if (queue_read) begin
            send_state <= SEND_REQ;
          end
        end
        SEND_REQ: begin
          // Consumer took it, drop req
          if (out_ack) begin
            send_state <= SEND_IDLE;
          end
        end
        default: send_state <= SEND_IDLE;
      endcase
    end
  end

  // Output data held steady while req is high
  always_ff @(posedge clock) begin
    if (queue_read) begin
      out_tag   <= queue_rdata.tag;
      out_value <= queue_rdata.value;
      out_flag  <= queue_rdata.flag;
    end
  end

endmodule

// File: src/cmd_execute.sv
// Single-cycle ALU stage
module cmd_execute
  import cmd_pkg::*;
(
  input  logic                clock,
  input  logic                resetn,
  // From decode
  input  logic                dec_valid,
  input  opcode_e             dec_op,
  input  logic [DATA_W-1:0]   dec_a,
  input  logic [DATA_W-1:0]   dec_b,
  input  logic [TAG_W-1:0]    dec_tag,
  output logic                exe_ready,
  // Towards the result stage
  output logic                exe_valid,
  output result_t             exe_result,
  input  logic                res_ready
);

  // Extra top bit holds carry or borrow
  logic [DATA_W:0]     sum;
  logic [DATA_W:0]     diff;
  logic [DATA_W-1:0]   alu_value;
  logic                alu_flag;
  logic                take;

  assign exe_ready = !exe_valid || res_ready;
  assign take      = dec_valid && exe_ready;

  always_comb begin
    sum       = {1'b0, dec_a} + {1'b0, dec_b};
    diff      = {1'b0, dec_a} - {1'b0, dec_b};
    alu_flag  = 1'b0;
    case (dec_op)
      ADD: begin
        alu_value = sum[DATA_W-1:0];
        alu_flag  = sum[DATA_W];
      end
      SUB: begin
        // Wraps below zero, top bit is the borrow
        alu_value = diff[DATA_W-1:0];
        alu_flag  = diff[DATA_W];
      end
      AND: alu_value = dec_a & dec_b;
      OR:  alu_value = dec_a | dec_b;
      XOR: alu_value = dec_a ^ dec_b;
      SHL: alu_value = dec_a << dec_b[SHIFT_W-1:0];
      SHR: alu_value = dec_a >> dec_b[SHIFT_W-1:0];
      // Unsigned compare
      MAX: alu_value = (dec_a > dec_b) ? dec_a : dec_b;
      default: alu_value = '0;
    endcase
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      exe_valid <= 1'b0;
    end else if (take) begin
      exe_valid <= 1'b1;
    end else if (res_ready) begin
      exe_valid <= 1'b0;
    end
  end

  // Result register
  always_ff @(posedge clock) begin
    if (take) begin
      exe_result.tag   <= dec_tag;
      exe_result.value <= alu_value;
      exe_result.flag  <= alu_flag;
    end
  end

endmodule

// File: src/cmd_decode.sv
// Command decode stage
module cmd_decode
  import cmd_pkg::*;
(
  input  logic                clock,
  input  logic                resetn,
  // Command queue read side
  input  logic                queue_grant,
  input  cmd_t                queue_data,
  output logic                queue_read,
  // Towards execute
  output logic                dec_valid,
  output opcode_e             dec_op,
  output logic [DATA_W-1:0]   dec_a,
  output logic [DATA_W-1:0]   dec_b,
  output logic [TAG_W-1:0]    dec_tag,
  input  logic                exe_ready
);

  opcode_e             next_op;
  logic [DATA_W-1:0]   next_a;
  logic [DATA_W-1:0]   next_b;

  // Pop when the head is granted and our register frees up
  assign queue_read = queue_grant && (!dec_valid || exe_ready);

  always_comb begin
    next_op = queue_data.opcode;
    next_a  = queue_data.a;
    next_b  = queue_data.b;
    case (queue_data.opcode)
      // Only the low bits of b count as shift amount
      SHL, SHR: next_b = {{(DATA_W-SHIFT_W){1'b0}}, queue_data.b[SHIFT_W-1:0]};
      ADD, SUB, AND, OR, XOR, MAX: next_b = queue_data.b;
      default: begin
        // Unknown code becomes AND with zero, so the result is zero
        next_op = AND;
        next_a  = '0;
        next_b  = '0;
      end
    endcase
  end

  // Valid bit
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      dec_valid <= 1'b0;
    end else if (queue_read) begin
      dec_valid <= 1'b1;
    end else if (exe_ready) begin
      dec_valid <= 1'b0;
    end
  end

  // Decoded fields
  always_ff @(posedge clock) begin
    if (queue_read) begin
      dec_op  <= next_op;
      dec_a   <= next_a;
      dec_b   <= next_b;
      dec_tag <= queue_data.tag;
    end
  end

endmodule

// File: src/cmd_intake.sv
// Four-phase command receiver
module cmd_intake
  import cmd_pkg::*;
(
  input  logic                clock,
  input  logic                resetn,
  // Producer port
  input  logic                in_req,
  input  logic [2:0]          in_opcode,
  input  logic [DATA_W-1:0]   in_a,
  input  logic [DATA_W-1:0]   in_b,
  input  logic [TAG_W-1:0]    in_tag,
  output logic                in_ack,
  // Command queue write side
  input  logic                queue_full,
  output logic                queue_write,
  output cmd_t                queue_data
);

  // New request not yet acknowledged and room to store it
  assign queue_write = in_req && !in_ack && !queue_full;

  // Ack is the receiver state
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      in_ack <= 1'b0;
    end else if (queue_write) begin
      // Command stored this edge
      in_ack <= 1'b1;
    end else if (in_ack && !in_req) begin
      // Producer released, return to zero
      in_ack <= 1'b0;
    end
  end

  // Pack the loose inputs into one payload
  always_comb begin
    queue_data.opcode = opcode_e'(in_opcode);
    queue_data.a      = in_a;
    queue_data.b      = in_b;
    queue_data.tag    = in_tag;
  end

endmodule

// File: fifo/fifo_controller.sv
// Synchronous FIFO controller
module fifo_controller #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic                       clock,
  input  logic                       resetn,
  // Write side
  input  logic                       write_enable,
  input  PAYLOAD_T                   write_data,
  output logic                       full,
  // Read side
  input  logic                       read_enable,
  output PAYLOAD_T                   read_data,
  output logic                       empty,
  output logic                       read_grant,
  // Single port to the storage array
  output logic                       memory_write_enable,
  output logic [$clog2(DEPTH)-1:0]   memory_address,
  output PAYLOAD_T                   memory_write_data,
  input  PAYLOAD_T                   memory_read_data
);

  localparam int AW = $clog2(DEPTH);

  // Pointers carry one extra wrap bit above the address
  logic [AW:0] write_pointer;
  logic [AW:0] read_pointer;
  logic        do_write;
  logic        do_read;

  // Same address, same lap means nothing stored
  assign empty = (write_pointer[AW-1:0] == read_pointer[AW-1:0]) &&
                 (write_pointer[AW] == read_pointer[AW]);
  // Same address, writer one lap ahead
  assign full  = (write_pointer[AW-1:0] == read_pointer[AW-1:0]) &&
                 (write_pointer[AW] != read_pointer[AW]);

  // Writes into a full queue are dropped
  assign do_write = write_enable && !full;

  // Port is taken by a write, so reads only get it in idle write cycles
  assign read_grant = !empty && !do_write;
  assign do_read    = read_enable && read_grant;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      write_pointer <= '0;
      read_pointer  <= '0;
    end else begin
      if (do_write) begin
        write_pointer <= write_pointer + 1'b1;
      end
      if (do_read) begin
        read_pointer <= read_pointer + 1'b1;
      end
    end
  end

  // Steer the shared address
  assign memory_write_enable = do_write;
  assign memory_address      = do_write ? write_pointer[AW-1:0] : read_pointer[AW-1:0];
  assign memory_write_data   = write_data;

  // Head entry comes straight back from the array
  assign read_data = memory_read_data;

endmodule

// File: fifo/fifo_memory.sv
// Register array storage
module fifo_memory #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic                       clock,
  input  logic                       write_enable,
  input  logic [$clog2(DEPTH)-1:0]   address,
  input  PAYLOAD_T                   write_data,
  output PAYLOAD_T                   read_data
);

  // One entry per queue slot
  PAYLOAD_T storage [DEPTH];

  // Written on the clock edge at the shared address
  always_ff @(posedge clock) begin
    if (write_enable) begin
      storage[address] <= write_data;
    end
  end

  // Combinational read at the same address
  assign read_data = storage[address];

endmodule

// File: common/cmd_pkg.sv
// Command and result payload types
package cmd_pkg;

  // Operand and tag widths
  localparam int DATA_W = 16;
  localparam int TAG_W = 4;

  // Shift amount taken from the low bits of operand b
  localparam int SHIFT_W = 4;

  // Opcode encoding, all eight codes assigned
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SHL = 3'd5,
    SHR = 3'd6,
    MAX = 3'd7
  } opcode_e;

  // Queued command, 39 bits
  typedef struct packed {
    opcode_e             opcode;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
    logic [TAG_W-1:0]    tag;
  } cmd_t;

  // Queued result, 21 bits
  // Flag is carry for ADD, borrow for SUB, zero otherwise
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [DATA_W-1:0]   value;
    logic                flag;
  } result_t;

endpackage

// File: common/queue_pkg.sv
// Queue depth constants
package queue_pkg;

  // Command queue entries between intake and decode
  // Must stay a power of two for the wrap-bit pointers
  localparam int CMD_DEPTH = 4;

  // Result queue entries between execute and the output port
  // Deeper than the command side to absorb a slow consumer
  localparam int RES_DEPTH = 8;

endpackage
